/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_pkg.sv
      - verilog/rv_ifaces.sv
      - verilog/rv_decode.sv
      - verilog/rv_execute.sv
      - verilog/rv_result.sv
      - verilog/rv_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_rv_core.sv

/* rv_core.f */
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_ifaces.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core.sv
tests/tb_rv_core.sv

/* tests/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int max_rows   = 80;
    localparam int wait_limit = 50;

    logic        clk;
    logic        rst_n;
    logic        inst_req;
    logic [31:0] inst;
    logic        inst_ack;
    logic        retire_valid;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic [31:0] pc;

    // one row per instruction
    logic [31:0] t_inst [max_rows];
    logic        t_we   [max_rows];
    logic [4:0]  t_rd   [max_rows];
    logic [31:0] t_data [max_rows];
    logic [31:0] t_pc   [max_rows];   // pc after retirement

    int          n_rows;
    logic [31:0] pc_m;      // expected pc while rows are added
    int          seed;
    int          errors;
    int          row_errs;
    int          passed;
    int          failed;
    bit          stalled;

    rv_core i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_req     (inst_req),
        .inst         (inst),
        .inst_ack     (inst_ack),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .pc           (pc)
    );

    always #10 clk = ~clk;

    // RV32I encodings
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic add_row(input logic [31:0] word, input logic we, input logic [4:0] rd,
                           input logic [31:0] data, input logic [31:0] next_pc);
        t_inst[n_rows] = word;
        t_we[n_rows]   = we;
        t_rd[n_rows]   = rd;
        t_data[n_rows] = data;
        t_pc[n_rows]   = next_pc;
        n_rows++;
        pc_m = next_pc;
    endtask

    task automatic alu_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm, input logic [31:0] exp);
        add_row(i_word(imm, rs1, f3, rd, 7'h13), 1'b1, rd, exp, pc_m + 4);
    endtask

    task automatic alu_reg(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [31:0] exp);
        add_row(r_word(f7, rs2, rs1, f3, rd), 1'b1, rd, exp, pc_m + 4);
    endtask

    task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [12:0] off, input logic taken);
        logic [31:0] target;
        target = taken ? pc_m + {{19{off[12]}}, off} : pc_m + 4;
        add_row(b_word(off, rs2, rs1, f3), 1'b0, 5'd0, 32'd0, target);
    endtask

    // loads and stores all use x27 as base
    task automatic load(input logic [2:0] f3, input logic [4:0] rd, input logic [11:0] off,
                        input logic [31:0] exp);
        add_row(i_word(off, 5'd27, f3, rd, 7'h03), 1'b1, rd, exp, pc_m + 4);
    endtask

    task automatic store(input logic [2:0] f3, input logic [4:0] rs2, input logic [11:0] off);
        add_row(s_word(off, rs2, 5'd27, f3), 1'b0, 5'd0, 32'd0, pc_m + 4);
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] up;
        logic [11:0] lo;
        logic [31:0] mword;
        a      = 32'hffff_fffb;   // x1 = -5
        b      = 32'd7;           // x2
        r1     = $random(seed);
        r2     = $random(seed);
        up     = {r1[19:0], 12'h000};
        lo     = r2[11:0];
        n_rows = 0;
        pc_m   = 32'h0;
        alu_imm(3'd0, 5'd1, 5'd0, 12'hffb, a);
        alu_imm(3'd0, 5'd2, 5'd0, 12'h007, b);
        alu_imm(3'd2, 5'd3, 5'd1, 12'h000, ($signed(a) < 0) ? 32'd1 : 32'd0);
        alu_imm(3'd3, 5'd4, 5'd1, 12'h005, (a < 32'd5) ? 32'd1 : 32'd0);
        alu_imm(3'd4, 5'd5, 5'd2, 12'h0f0, b ^ 32'h0f0);
        alu_imm(3'd6, 5'd6, 5'd2, 12'h100, b | 32'h100);
        alu_imm(3'd7, 5'd7, 5'd1, 12'h0ff, a & 32'h0ff);
        alu_imm(3'd1, 5'd8, 5'd2, 12'h004, b << 4);
        alu_imm(3'd5, 5'd9, 5'd1, 12'h01c, a >> 28);
        alu_imm(3'd5, 5'd10, 5'd1, 12'h401, $signed(a) >>> 1);   // srai
        alu_reg(7'h00, 3'd0, 5'd11, 5'd1, 5'd2, a + b);
        alu_reg(7'h20, 3'd0, 5'd12, 5'd2, 5'd1, b - a);
        alu_reg(7'h00, 3'd2, 5'd13, 5'd1, 5'd2, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        alu_reg(7'h00, 3'd3, 5'd14, 5'd1, 5'd2, (a < b) ? 32'd1 : 32'd0);
        alu_reg(7'h20, 3'd5, 5'd15, 5'd1, 5'd2, $signed(a) >>> b[4:0]);
        alu_reg(7'h00, 3'd7, 5'd16, 5'd1, 5'd2, a & b);
        alu_reg(7'h00, 3'd6, 5'd17, 5'd1, 5'd2, a | b);
        alu_reg(7'h00, 3'd4, 5'd18, 5'd1, 5'd2, a ^ b);
        alu_reg(7'h00, 3'd1, 5'd19, 5'd2, 5'd2, b << b[4:0]);
        alu_reg(7'h00, 3'd5, 5'd20, 5'd1, 5'd2, a >> b[4:0]);
        // upper immediates, random pair
        add_row(u_word(r1[19:0], 5'd21, 7'h37), 1'b1, 5'd21, up, pc_m + 4);
        alu_imm(3'd0, 5'd21, 5'd21, lo, up + {{20{lo[11]}}, lo});
        add_row(u_word(20'h12345, 5'd22, 7'h17), 1'b1, 5'd22, 32'h1234_5000 + pc_m, pc_m + 4);
        alu_imm(3'd0, 5'd0, 5'd0, 12'h005, 32'd5);   // reported, not kept
        alu_reg(7'h00, 3'd0, 5'd23, 5'd0, 5'd2, b);
        // branches, taken and not taken
        branch(3'd0, 5'd2, 5'd2, 13'd12, b == b);
        branch(3'd0, 5'd1, 5'd2, 13'd12, a == b);
        branch(3'd1, 5'd1, 5'd2, 13'd12, a != b);
        branch(3'd1, 5'd2, 5'd2, 13'd12, b != b);
        branch(3'd4, 5'd1, 5'd2, 13'd12, $signed(a) < $signed(b));
        branch(3'd4, 5'd2, 5'd1, 13'd12, $signed(b) < $signed(a));
        branch(3'd5, 5'd2, 5'd1, 13'd12, $signed(b) >= $signed(a));
        branch(3'd5, 5'd1, 5'd2, 13'd12, $signed(a) >= $signed(b));
        branch(3'd6, 5'd2, 5'd1, 13'd12, b < a);
        branch(3'd6, 5'd1, 5'd2, 13'd12, a < b);
        branch(3'd7, 5'd1, 5'd2, 13'd12, a >= b);
        branch(3'd7, 5'd2, 5'd1, 13'd12, b >= a);
        branch(3'd1, 5'd1, 5'd0, 13'h1ff0, a != 32'd0);   // backward by 16
        // jumps
        add_row(j_word(21'd20, 5'd24), 1'b1, 5'd24, pc_m + 4, pc_m + 20);
        alu_imm(3'd0, 5'd25, 5'd0, 12'h101, 32'h101);
        add_row(i_word(12'h010, 5'd25, 3'd0, 5'd26, 7'h67), 1'b1, 5'd26, pc_m + 4,
                (32'h101 + 32'h010) & ~32'h1);
        // memory
        alu_imm(3'd0, 5'd27, 5'd0, 12'h040, 32'h40);
        add_row(u_word(20'h89abd, 5'd28, 7'h37), 1'b1, 5'd28, 32'h89ab_d000, pc_m + 4);
        mword = 32'h89ab_d000 + 32'hffff_fdef;
        alu_imm(3'd0, 5'd28, 5'd28, 12'hdef, mword);
        store(3'd2, 5'd28, 12'd0);
        load(3'd2, 5'd29, 12'd0, mword);
        load(3'd0, 5'd30, 12'd0, {{24{mword[7]}}, mword[7:0]});
        load(3'd4, 5'd30, 12'd1, {24'h0, mword[15:8]});
        load(3'd1, 5'd31, 12'd2, {{16{mword[31]}}, mword[31:16]});
        load(3'd5, 5'd31, 12'd0, {16'h0, mword[15:0]});
        store(3'd0, 5'd2, 12'd1);     // sb into byte 1
        mword[15:8] = b[7:0];
        store(3'd1, 5'd1, 12'd2);     // sh into upper half
        mword[31:16] = a[15:0];
        load(3'd2, 5'd29, 12'd0, mword);
        load(3'd0, 5'd30, 12'd1, {{24{mword[15]}}, mword[15:8]});
        load(3'd5, 5'd31, 12'd2, {16'h0, mword[31:16]});
        load(3'd1, 5'd31, 12'd2, {{16{mword[31]}}, mword[31:16]});
        // ecall and an undecodable word retire as nops
        add_row(32'h0000_0073, 1'b0, 5'd0, 32'd0, pc_m + 4);
        add_row(32'hffff_ffff, 1'b0, 5'd0, 32'd0, pc_m + 4);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        if (got !== exp) begin
            $display("Fail %s exp %h got %h", name, exp, got);
            errors++;
            row_errs++;
        end
    endtask

    task automatic report_stall(input int i, input string what);
        $display("row %0d: %s within %0d cycles, core stalled", i, what, wait_limit);
        errors++;
        failed++;
        stalled = 1'b1;
    endtask

    // one four-phase handshake, entered and left 1 ns after a rising edge
    task automatic run_row(input int i);
        int cyc;
        row_errs = 0;
        inst     = t_inst[i];
        inst_req = 1'b1;
        cyc      = 0;
        while (!inst_ack && cyc < wait_limit) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!inst_ack) begin
            report_stall(i, "inst_ack did not rise");
            return;
        end
        expect_eq("inst_ack delay", 32'd3, cyc);
        expect_eq("retire_valid", 32'd1, retire_valid);
        expect_eq("retire_we", t_we[i], retire_we);
        if (t_we[i]) begin
            expect_eq("retire_rd", t_rd[i], retire_rd);
            expect_eq("retire_data", t_data[i], retire_data);
        end
        expect_eq("pc", t_pc[i], pc);
        @(posedge clk);   // req still high, ack holds
        #1;
        expect_eq("inst_ack", 32'd1, inst_ack);
        expect_eq("retire_valid", 32'd0, retire_valid);
        inst_req = 1'b0;
        cyc      = 0;
        while (inst_ack && cyc < wait_limit) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (inst_ack) begin
            report_stall(i, "inst_ack did not fall");
            return;
        end
        if (row_errs == 0) begin
            passed++;
            $display("row %0d inst %h ok", i, t_inst[i]);
        end else begin
            failed++;
            $display("row %0d inst %h: %0d mismatches", i, t_inst[i], row_errs);
        end
    endtask

    initial begin
        int i;
        clk      = 1'b0;
        rst_n    = 1'b0;
        inst_req = 1'b0;
        inst     = 32'h0;
        errors   = 0;
        passed   = 0;
        failed   = 0;
        stalled  = 1'b0;
        seed     = 28;
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        row_errs = 0;
        repeat (3) begin   // idle after reset
            expect_eq("inst_ack", 32'd0, inst_ack);
            expect_eq("retire_valid", 32'd0, retire_valid);
            expect_eq("retire_we", 32'd0, retire_we);
            expect_eq("pc", 32'h0, pc);
            @(posedge clk);
            #1;
        end
        if (row_errs == 0) begin
            passed++;
            $display("reset state ok");
        end else begin
            failed++;
            $display("reset state: %0d mismatches", row_errs);
        end
        i = 0;
        while (i < n_rows && !stalled) begin
            run_row(i);
            i++;
        end
        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_req,
    input  logic [31:0]         inst,
    output logic                inst_ack,
    output logic                retire_valid,
    output logic                retire_we,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data,
    output logic [`RV_XLEN-1:0] pc
);

    dec_if dec_bus ();
    res_if res_bus ();

    rv_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst_req (inst_req),
        .inst     (inst),
        .inst_ack (inst_ack),
        .dec      (dec_bus.dec),
        .res      (res_bus.ctl)
    );

    rv_execute u_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .dec   (dec_bus.exe),
        .res   (res_bus.exe),
        .pc    (pc)
    );

    rv_result u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .res          (res_bus.res),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

/* verilog/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_req,
    input  logic [31:0] inst,
    output logic        inst_ack,
    dec_if.dec          dec,
    res_if.ctl          res
);

    typedef enum logic [1:0] {st_idle, st_busy, st_ack} state_e;

    state_e              state;
    inst_u               iw;       // latched instruction word
    logic [2:0]          f3;
    logic                shift_ok;
    logic                op_imm_ok;
    logic                op_reg_ok;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    // handshake FSM with one instruction in flight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            inst_ack  <= 1'b0;
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= 1'b0;   // single cycle pulse
            case (state)
                st_idle: if (inst_req) begin
                    state     <= st_busy;
                    dec.valid <= 1'b1;
                end
                st_busy: if (res.done) begin
                    state    <= st_ack;
                    inst_ack <= 1'b1;
                end
                st_ack: if (!inst_req) begin
                    state    <= st_idle;
                    inst_ack <= 1'b0;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && inst_req) iw <= inst;
    end

    assign f3 = iw.r.funct3;

    // one immediate per format view
    assign imm_i = {{(`RV_XLEN-12){iw.i.imm[11]}}, iw.i.imm};
    assign imm_s = {{(`RV_XLEN-12){iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
    assign imm_b = {{(`RV_XLEN-12){iw.b.imm12}}, iw.b.imm11, iw.b.imm10_5, iw.b.imm4_1, 1'b0};
    assign imm_u = {iw.u.imm, 12'b0};
    assign imm_j = {{(`RV_XLEN-20){iw.j.imm20}}, iw.j.imm19_12, iw.j.imm11, iw.j.imm10_1, 1'b0};

    // funct7 legality
    assign shift_ok  = (iw.r.funct7 == 7'h00) || (f3 == 3'd5 && iw.r.funct7 == 7'h20);
    assign op_imm_ok = (f3 != 3'd1 && f3 != 3'd5) || shift_ok;
    assign op_reg_ok = (iw.r.funct7 == 7'h00) ||
                       (iw.r.funct7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));

    always_comb begin
        dec.rs1          = iw.r.rs1;
        dec.rs2          = iw.r.rs2;
        dec.rd           = iw.r.rd;
        dec.imm          = imm_i;
        dec.alu_op       = alu_add;
        dec.a_sel        = a_rs1;
        dec.b_sel        = b_imm;
        dec.br_type      = br_none;
        dec.is_jal       = 1'b0;
        dec.is_jalr      = 1'b0;
        dec.wb_sel       = wb_none;   // anything not matched below is a nop
        dec.mem_rd       = 1'b0;
        dec.mem_wr       = 1'b0;
        dec.mem_size     = mem_word;
        dec.mem_unsigned = f3[2];
        case (iw.r.opcode)
            7'h37: begin   // lui
                dec.imm    = imm_u;
                dec.alu_op = alu_pass_b;
                dec.wb_sel = wb_alu;
            end
            7'h17: begin   // auipc
                dec.imm    = imm_u;
                dec.a_sel  = a_pc;
                dec.wb_sel = wb_alu;
            end
            7'h6f: begin
                dec.imm    = imm_j;
                dec.a_sel  = a_pc;
                dec.is_jal = 1'b1;
                dec.wb_sel = wb_pc4;
            end
            7'h67: if (f3 == 3'd0) begin
                dec.is_jalr = 1'b1;
                dec.wb_sel  = wb_pc4;
            end
            7'h63: begin
                dec.imm   = imm_b;
                dec.b_sel = b_rs2;
                case (f3)
                    3'd0: dec.br_type = br_eq;
                    3'd1: dec.br_type = br_ne;
                    3'd4: dec.br_type = br_lt;
                    3'd5: dec.br_type = br_ge;
                    3'd6: dec.br_type = br_ltu;
                    3'd7: dec.br_type = br_geu;
                    default: dec.br_type = br_none;
                endcase
            end
            7'h03: if (f3[1:0] != 2'd3 && !(f3[2] && f3[1])) begin
                dec.mem_rd   = 1'b1;
                dec.mem_size = mem_size_e'(f3[1:0]);
                dec.wb_sel   = wb_mem;
            end
            7'h23: if (!f3[2] && f3[1:0] != 2'd3) begin
                dec.imm      = imm_s;
                dec.mem_wr   = 1'b1;
                dec.mem_size = mem_size_e'(f3[1:0]);
            end
            7'h13: if (op_imm_ok) begin
                dec.alu_op = alu_op_e'({f3 == 3'd5 && iw.r.funct7[5], f3});
                dec.wb_sel = wb_alu;
            end
            7'h33: if (op_reg_ok) begin
                dec.b_sel  = b_rs2;
                dec.alu_op = alu_op_e'({iw.r.funct7[5], f3});
                dec.wb_sel = wb_alu;
            end
            default: ;
        endcase
    end

    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(inst_ack) |-> inst_req)
        else $error("inst_ack rose without a pending request");

endmodule

/* verilog/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path and address width
`define RV_XLEN 32

// data memory size in 32-bit words
`define RV_DMEM_WORDS 64

// first fetch address
`define RV_RESET_PC 32'h0000_0000

`endif

/* verilog/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_execute
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    dec_if.exe                  dec,
    res_if.exe                  res,
    output logic [`RV_XLEN-1:0] pc
);

    logic [`RV_XLEN-1:0] regs [32];   // x0 is never written
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_out;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] next_pc_q;
    logic [4:0]          shamt;
    logic                taken;

    assign rs1_val = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
    assign rs2_val = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

    assign op_a  = (dec.a_sel == a_pc) ? pc : rs1_val;
    assign op_b  = (dec.b_sel == b_imm) ? dec.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_sll:    alu_out = op_a << shamt;
            alu_slt:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            alu_xor:    alu_out = op_a ^ op_b;
            alu_srl:    alu_out = op_a >> shamt;
            alu_sra:    alu_out = $signed(op_a) >>> shamt;
            alu_or:     alu_out = op_a | op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // branch compare always on the register operands
    always_comb begin
        case (dec.br_type)
            br_eq:   taken = (rs1_val == rs2_val);
            br_ne:   taken = (rs1_val != rs2_val);
            br_lt:   taken = ($signed(rs1_val) < $signed(rs2_val));
            br_ge:   taken = ($signed(rs1_val) >= $signed(rs2_val));
            br_ltu:  taken = (rs1_val < rs2_val);
            br_geu:  taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + `RV_XLEN'd4;

    always_comb begin
        if (dec.is_jalr)
            next_pc = {alu_out[`RV_XLEN-1:1], 1'b0};   // rs1 + imm, bit 0 cleared
        else if (dec.is_jal || taken)
            next_pc = pc + dec.imm;
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res.valid  <= 1'b0;
            res.wb_sel <= wb_none;
            res.mem_rd <= 1'b0;
            res.mem_wr <= 1'b0;
        end else begin
            res.valid <= dec.valid;
            if (dec.valid) begin
                res.wb_sel <= dec.wb_sel;
                res.mem_rd <= dec.mem_rd;
                res.mem_wr <= dec.mem_wr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            res.alu_result   <= alu_out;
            res.store_data   <= rs2_val;
            res.pc_plus4     <= pc_plus4;
            res.rd           <= dec.rd;
            res.mem_size     <= dec.mem_size;
            res.mem_unsigned <= dec.mem_unsigned;
            next_pc_q        <= next_pc;
        end
    end

    // pc moves on the retire edge
    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= `RV_RESET_PC;
        else if (res.done)
            pc <= next_pc_q;
    end

    always_ff @(posedge clk) begin
        if (res.wb_we) regs[res.wb_rd] <= res.wb_data;
    end

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        res.wb_we |-> res.wb_rd != 5'd0)
        else $error("writeback targets x0");

endmodule

/* verilog/rv_ifaces.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

// decoded controls, valid for one cycle after the word is latched
interface dec_if
    import rv_pkg::*;
();
    logic                valid;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] imm;
    alu_op_e             alu_op;
    a_sel_e              a_sel;
    b_sel_e              b_sel;
    br_type_e            br_type;
    logic                is_jal;
    logic                is_jalr;
    wb_sel_e             wb_sel;
    logic                mem_rd;
    logic                mem_wr;
    mem_size_e           mem_size;
    logic                mem_unsigned;

    modport dec (
        output valid, rs1, rs2, rd, imm, alu_op, a_sel, b_sel, br_type,
               is_jal, is_jalr, wb_sel, mem_rd, mem_wr, mem_size, mem_unsigned
    );
    modport exe (
        input valid, rs1, rs2, rd, imm, alu_op, a_sel, b_sel, br_type,
              is_jal, is_jalr, wb_sel, mem_rd, mem_wr, mem_size, mem_unsigned
    );
endinterface

interface res_if
    import rv_pkg::*;
();
    logic                valid;
    logic [`RV_XLEN-1:0] alu_result;   // also the memory address
    logic [`RV_XLEN-1:0] store_data;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [4:0]          rd;
    wb_sel_e             wb_sel;
    logic                mem_rd;
    logic                mem_wr;
    mem_size_e           mem_size;
    logic                mem_unsigned;
    // writeback path back into the register file
    logic                wb_we;
    logic [4:0]          wb_rd;
    logic [`RV_XLEN-1:0] wb_data;
    logic                done;

    modport exe (
        output valid, alu_result, store_data, pc_plus4, rd, wb_sel,
               mem_rd, mem_wr, mem_size, mem_unsigned,
        input  wb_we, wb_rd, wb_data, done
    );
    modport res (
        input  valid, alu_result, store_data, pc_plus4, rd, wb_sel,
               mem_rd, mem_wr, mem_size, mem_unsigned,
        output wb_we, wb_rd, wb_data, done
    );
    modport ctl (input done);
endinterface

/* verilog/rv_pkg.sv */
package rv_pkg;

    // one view per base instruction format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    // low three bits follow funct3, bit 3 marks sub and sra
    typedef enum logic [3:0] {
        alu_add    = 4'b0000,
        alu_sll    = 4'b0001,
        alu_slt    = 4'b0010,
        alu_sltu   = 4'b0011,
        alu_xor    = 4'b0100,
        alu_srl    = 4'b0101,
        alu_or     = 4'b0110,
        alu_and    = 4'b0111,
        alu_sub    = 4'b1000,
        alu_sra    = 4'b1101,
        alu_pass_b = 4'b1110   // lui
    } alu_op_e;

    typedef enum logic {a_rs1, a_pc} a_sel_e;

    typedef enum logic {b_rs2, b_imm} b_sel_e;

    typedef enum logic [1:0] {
        wb_none = 2'b00,
        wb_pc4  = 2'b01,
        wb_alu  = 2'b10,
        wb_mem  = 2'b11
    } wb_sel_e;

    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_eq   = 3'd1,
        br_ne   = 3'd2,
        br_lt   = 3'd3,
        br_ge   = 3'd4,
        br_ltu  = 3'd5,
        br_geu  = 3'd6
    } br_type_e;

    // same order as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {mem_byte, mem_half, mem_word} mem_size_e;

endpackage

/* verilog/rv_result.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_result
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    res_if.res                  res,
    output logic                retire_valid,
    output logic                retire_we,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data
);

    localparam int dmem_aw = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
    logic [dmem_aw-1:0]  widx;
    logic [1:0]          boff;
    logic [4:0]          rshift;
    logic [`RV_XLEN-1:0] rword;
    logic [`RV_XLEN-1:0] lane;
    logic [`RV_XLEN-1:0] load_val;
    logic [`RV_XLEN-1:0] wdata;
    logic [3:0]          be;

    assign widx   = res.alu_result[dmem_aw+1:2];   // word addressed
    assign boff   = res.alu_result[1:0];
    assign rword  = dmem[widx];
    assign rshift = (res.mem_size == mem_half) ? {boff[1], 4'b0000} : {boff, 3'b000};
    assign lane   = rword >> rshift;

    always_comb begin
        case (res.mem_size)
            mem_byte: load_val = res.mem_unsigned ? {24'b0, lane[7:0]} :
                                                    {{24{lane[7]}}, lane[7:0]};
            mem_half: load_val = res.mem_unsigned ? {16'b0, lane[15:0]} :
                                                    {{16{lane[15]}}, lane[15:0]};
            default:  load_val = rword;
        endcase
    end

    // replicate store data across lanes and pick the byte enables
    always_comb begin
        case (res.mem_size)
            mem_byte: begin
                be    = 4'b0001 << boff;
                wdata = {4{res.store_data[7:0]}};
            end
            mem_half: begin
                be    = boff[1] ? 4'b1100 : 4'b0011;
                wdata = {2{res.store_data[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = res.store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (res.valid && res.mem_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) dmem[widx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        case (res.wb_sel)
            wb_alu:  res.wb_data = res.alu_result;
            wb_pc4:  res.wb_data = res.pc_plus4;
            wb_mem:  res.wb_data = load_val;
            default: res.wb_data = '0;
        endcase
    end

    assign res.wb_we = res.valid && res.wb_sel != wb_none && res.rd != 5'd0;
    assign res.wb_rd = res.rd;
    assign res.done  = res.valid;   // retire edge follows

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= res.valid;
            retire_we    <= res.valid && res.wb_sel != wb_none;   // x0 writes still reported
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid) begin
            retire_rd   <= res.rd;
            retire_data <= res.wb_data;
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(res.mem_rd && res.mem_wr))
        else $error("load and store decoded together");

endmodule
